// File: dma_rx.f
+incdir+dv
rtl/dma_rx_pkg.sv
rtl/dscq.sv
rtl/pkt_plan.sv
rtl/pkt_issue.sv
rtl/cmpl_track.sv
rtl/rx_err_reg.sv
rtl/dma_rx.sv
dv/tb_dma_rx.sv

// File: dv/tb_dma_rx_tests.svh
// first packet runs to the window end and later packets fill whole windows
function automatic void model_split(input logic [63:0] addr, input logic [31:0] len,
                                    input int mode, output int unsigned num,
                                    output int unsigned sta, output int unsigned fin);
  int unsigned m;
  int unsigned off;
  int unsigned first;
  int unsigned l;
  int unsigned r;
  m     = 32'd1 << ((mode > 4) ? 4 : mode);
  l     = len >> 6;
  off   = 32'((addr >> 6) % 64'(m));
  first = m - off;
  if (l <= first) begin
    num = 1;
    sta = l;
    fin = l;
  end else begin
    r   = l - first;
    num = 1 + (r + m - 1) / m;
    sta = first;
    fin = ((r % m) == 0) ? m : r % m;
  end
endfunction

function automatic logic [63:0] model_pkt_addr(input logic [63:0] addr, input int mode,
                                               input int unsigned k);
  logic [63:0] win;
  logic [63:0] res;
  win = 64'd1 << (6 + ((mode > 4) ? 4 : mode));
  if (k == 0) begin
    res = {addr[63:6], 6'b0};
  end else begin
    res = (addr & ~(win - 64'd1)) + 64'(k) * win;
  end
  return res;
endfunction

task automatic enqueue_dsc(input logic [63:0] addr, input logic [31:0] len,
                           input logic [15:0] id);
  dscq_we      = 1'b1;
  dsc_src_addr = addr;
  dsc_src_len  = len;
  dsc_task_id  = id;
  next_cycle();
  dscq_we = 1'b0;
endtask

task automatic wait_send_valid();
  int n;
  n = 0;
  while (pkt_send_valid !== 1'b1 && n < 40) begin
    next_cycle();
    n++;
  end
  if (pkt_send_valid !== 1'b1) begin
    report_fail("timeout waiting for pkt_send_valid to rise");
  end
endtask

task automatic wait_wt_req(input logic level);
  int n;
  n = 0;
  while (que_wt_req !== level && n < 40) begin
    next_cycle();
    n++;
  end
  if (que_wt_req !== level) begin
    report_fail($sformatf("timeout waiting for que_wt_req to become %0b", level));
  end
endtask

task automatic wait_not_busy();
  int n;
  n = 0;
  while (dmar_busy !== 1'b0 && n < 40) begin
    next_cycle();
    n++;
  end
  if (dmar_busy !== 1'b0) begin
    report_fail("timeout waiting for dmar_busy to fall");
  end
endtask

// one go every two cycles; tail follows the go when do_tail is set
task automatic send_packets(input logic [63:0] addr, input logic [31:0] len, input int mode,
                            input logic do_tail, output int unsigned sent);
  int unsigned num;
  int unsigned sta;
  int unsigned fin;
  int unsigned k;
  model_split(addr, len, mode, num, sta, fin);
  sent = 0;
  wait_send_valid();
  check_val("pkt_num", 64'(pkt_num), 64'(num));
  check_val("pkt_sta_cycle", 64'(pkt_sta_cycle), 64'(sta));
  check_val("pkt_end_cycle", 64'(pkt_end_cycle), 64'(fin));
  for (k = 0; k < num; k++) begin
    if (pkt_send_valid !== 1'b1) begin
      report_fail($sformatf("pkt_send_valid fell after %0d of %0d packets", k, num));
      break;
    end
    check_val("pkt_send_idx", 64'(pkt_send_idx), 64'(k));
    check_val("pkt_send_addr", pkt_send_addr, model_pkt_addr(addr, mode, k));
    pkt_send_go = 1'b1;
    next_cycle();
    pkt_send_go = 1'b0;
    pkt_tail    = do_tail;
    next_cycle();
    pkt_tail = 1'b0;
    sent++;
  end
  check_val("pkt_send_valid", 64'(pkt_send_valid), 64'd0);
endtask

task automatic pulse_last_tail();
  dsc_last_tail = 1'b1;
  next_cycle();
  dsc_last_tail = 1'b0;
endtask

task automatic retire_dsc(input logic [15:0] id);
  wait_wt_req(1'b1);
  check_val("que_wt_task_id", 64'(que_wt_task_id), 64'(id));
  que_wt_ack = 1'b1;
  next_cycle();
  que_wt_ack = 1'b0;
endtask

task automatic pulse_err_clr();
  err_clr = 1'b1;
  next_cycle();
  err_clr = 1'b0;
endtask

task automatic check_reset_state();
  start_test();
  check_val("pkt_send_valid", 64'(pkt_send_valid), 64'd0);
  check_val("que_wt_req", 64'(que_wt_req), 64'd0);
  check_val("dmar_busy", 64'(dmar_busy), 64'd0);
  check_val("dscq_full", 64'(dscq_full), 64'd0);
  check_val("rx_err", 64'(rx_err), 64'd0);
  end_test("reset state");
endtask

task automatic split_packets_all_modes();
  logic [63:0] addr;
  logic [63:0] win;
  logic [31:0] len;
  logic [15:0] id;
  int unsigned sent;
  start_test();
  for (int mode = 0; mode <= 4; mode++) begin
    pkt_max_len_mode = 3'(mode);
    win              = 64'd1 << (6 + mode);
    for (int j = 0; j < 3; j++) begin
      addr = {$urandom, $urandom};
      // j picks window aligned, last cycle of a window or fully random
      if (j == 0) begin
        addr = addr & ~(win - 64'd1);
      end else if (j == 1) begin
        addr = (addr & ~(win - 64'd1)) | ((win - 64'd64) | 64'(6'($urandom)));
      end
      len      = 32'(($urandom % 40) + 1) << 6;
      len[5:0] = 6'($urandom);
      id       = 16'($urandom);
      enqueue_dsc(addr, len, id);
      send_packets(addr, len, mode, 1'b1, sent);
      pulse_last_tail();
      retire_dsc(id);
      wait_wt_req(1'b0);
    end
  end
  wait_not_busy();
  end_test("packet split");
endtask

task automatic fill_and_overflow();
  start_test();
  rxch_rd_enb = 1'b0;
  check_val("dscq_full", 64'(dscq_full), 64'd0);
  for (int i = 0; i < 4; i++) begin
    enqueue_dsc(64'h4000 + 64'(i) * 64'h1000, 32'h100, 16'(16'h100 + i));
  end
  check_val("dscq_full", 64'(dscq_full), 64'd1);
  enqueue_dsc(64'h9000, 32'h100, 16'h1ff);
  check_val("rx_err", 64'(rx_err), 64'(1 << err_dscq_wr_ovfl));
  // the dropped write must not have touched the oldest entry
  check_val("que_wt_task_id", 64'(que_wt_task_id), 64'h100);
  pulse_err_clr();
  check_val("rx_err", 64'(rx_err), 64'd0);
  rxch_clr = 1'b1;
  next_cycle();
  rxch_clr = 1'b0;
  check_val("dscq_full", 64'(dscq_full), 64'd0);
  rxch_rd_enb = 1'b1;
  wait_not_busy();
  end_test("queue overflow");
endtask

task automatic retire_in_order();
  logic [63:0] addrs [3];
  logic [31:0] lens [3];
  logic [15:0] ids [3];
  int unsigned sent;
  int unsigned total;
  start_test();
  addrs = '{64'h1000_0040, 64'h2000_0100, 64'h3000_03c0};
  lens  = '{32'h2c0, 32'h400, 32'h80};
  ids   = '{16'h0a11, 16'h0b22, 16'h0c33};
  total = 0;
  pkt_max_len_mode = 3'd2;
  for (int i = 0; i < 3; i++) begin
    enqueue_dsc(addrs[i], lens[i], ids[i]);
  end
  for (int i = 0; i < 3; i++) begin
    send_packets(addrs[i], lens[i], 2, 1'b0, sent);
    total += sent;
  end
  check_val("dmar_busy", 64'(dmar_busy), 64'd1);
  for (int i = 0; i < 3; i++) begin
    pulse_last_tail();
  end
  for (int i = 0; i < 3; i++) begin
    retire_dsc(ids[i]);
  end
  next_cycle();
  next_cycle();
  check_val("que_wt_req", 64'(que_wt_req), 64'd0);
  // packets still in flight keep the channel busy
  check_val("dmar_busy", 64'(dmar_busy), 64'd1);
  for (int unsigned i = 0; i < total; i++) begin
    pkt_tail = 1'b1;
    next_cycle();
  end
  pkt_tail = 1'b0;
  wait_not_busy();
  end_test("completion order");
endtask

task automatic zero_length_dsc();
  int   n;
  logic saw_valid;
  start_test();
  n         = 0;
  saw_valid = 1'b0;
  check_val("rx_err", 64'(rx_err), 64'd0);
  enqueue_dsc({$urandom, $urandom}, 32'h3f, 16'h5a5a);
  while (que_wt_req !== 1'b1 && n < 40) begin
    if (pkt_send_valid === 1'b1) begin
      saw_valid = 1'b1;
    end
    next_cycle();
    n++;
  end
  if (que_wt_req !== 1'b1) begin
    report_fail("timeout waiting for que_wt_req after a zero-length descriptor");
  end
  // valid stays low after the request too
  for (int i = 0; i < 4; i++) begin
    if (pkt_send_valid === 1'b1) begin
      saw_valid = 1'b1;
    end
    next_cycle();
  end
  check_val("pkt_send_valid", 64'(saw_valid), 64'd0);
  retire_dsc(16'h5a5a);
  wait_wt_req(1'b0);
  // nothing left to retire and no request pending
  que_wt_ack = 1'b1;
  next_cycle();
  que_wt_ack = 1'b0;
  check_val("rx_err", 64'(rx_err), 64'((1 << err_req_udfl) | (1 << err_retire_udfl)));
  pulse_err_clr();
  check_val("rx_err", 64'(rx_err), 64'd0);
  wait_not_busy();
  end_test("zero length");
endtask

task automatic gate_and_clear();
  logic saw_valid;
  start_test();
  saw_valid        = 1'b0;
  rxch_rd_enb      = 1'b0;
  pkt_max_len_mode = 3'd2;
  for (int i = 0; i < 4; i++) begin
    enqueue_dsc(64'h8000 + 64'(i) * 64'h400, 32'h100, 16'(16'h700 + i));
  end
  for (int i = 0; i < 8; i++) begin
    saw_valid = saw_valid | pkt_send_valid;
    next_cycle();
  end
  check_val("pkt_send_valid", 64'(saw_valid), 64'd0);
  check_val("dscq_full", 64'(dscq_full), 64'd1);
  rxch_clr = 1'b1;
  next_cycle();
  rxch_clr    = 1'b0;
  rxch_rd_enb = 1'b1;
  check_val("dscq_full", 64'(dscq_full), 64'd0);
  for (int i = 0; i < 8; i++) begin
    saw_valid = saw_valid | pkt_send_valid | que_wt_req;
    next_cycle();
  end
  check_val("pkt_send_valid", 64'(saw_valid), 64'd0);
  wait_not_busy();
  end_test("read gate and clear");
endtask

// File: dv/tb_dma_rx.sv
`timescale 1ns/1ps

module tb_dma_rx import dma_rx_pkg::*; ();

  logic        user_clk;
  logic        reset_n;
  max_mode_t   pkt_max_len_mode;
  logic        rxch_rd_enb;
  logic        rxch_clr;
  logic        dscq_we;
  addr_t       dsc_src_addr;
  len_t        dsc_src_len;
  task_id_t    dsc_task_id;
  logic        pkt_send_go;
  logic        pkt_tail;
  logic        dsc_last_tail;
  logic        que_wt_ack;
  logic        err_clr;
  logic        dscq_full;
  logic        pkt_send_valid;
  addr_t       pkt_send_addr;
  pkt_num_t    pkt_num;
  pkt_cyc_t    pkt_sta_cycle;
  pkt_cyc_t    pkt_end_cycle;
  pkt_num_t    pkt_send_idx;
  logic        que_wt_req;
  task_id_t    que_wt_task_id;
  logic        dmar_busy;
  err_vec_t    rx_err;

  int unsigned seed_val;
  int          check_cnt;
  int          err_cnt;
  int          test_cnt;
  int          test_err_base;

  dma_rx #(
    .DSCQ_DEPTH(4)
  ) dut (
    .user_clk         (user_clk),
    .reset_n          (reset_n),
    .pkt_max_len_mode (pkt_max_len_mode),
    .rxch_rd_enb      (rxch_rd_enb),
    .rxch_clr         (rxch_clr),
    .dscq_we          (dscq_we),
    .dsc_src_addr     (dsc_src_addr),
    .dsc_src_len      (dsc_src_len),
    .dsc_task_id      (dsc_task_id),
    .pkt_send_go      (pkt_send_go),
    .pkt_tail         (pkt_tail),
    .dsc_last_tail    (dsc_last_tail),
    .que_wt_ack       (que_wt_ack),
    .err_clr          (err_clr),
    .dscq_full        (dscq_full),
    .pkt_send_valid   (pkt_send_valid),
    .pkt_send_addr    (pkt_send_addr),
    .pkt_num          (pkt_num),
    .pkt_sta_cycle    (pkt_sta_cycle),
    .pkt_end_cycle    (pkt_end_cycle),
    .pkt_send_idx     (pkt_send_idx),
    .que_wt_req       (que_wt_req),
    .que_wt_task_id   (que_wt_task_id),
    .dmar_busy        (dmar_busy),
    .rx_err           (rx_err)
  );

  initial begin
    user_clk = 1'b0;
    forever #4 user_clk = ~user_clk;
  end

  // inputs change and outputs are sampled 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge user_clk);
    #1;
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_fail(input string msg);
    err_cnt++;
    $display("%s, at %0t", msg, $time);
  endtask

  task automatic start_test();
    test_err_base = err_cnt;
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt == test_err_base) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_cnt - test_err_base);
    end
  endtask

  `include "tb_dma_rx_tests.svh"

  initial begin
    seed_val         = $urandom(82239);
    check_cnt        = 0;
    err_cnt          = 0;
    test_cnt         = 0;
    test_err_base    = 0;
    reset_n          = 1'b0;
    pkt_max_len_mode = '0;
    rxch_rd_enb      = 1'b1;
    rxch_clr         = 1'b0;
    dscq_we          = 1'b0;
    dsc_src_addr     = '0;
    dsc_src_len      = '0;
    dsc_task_id      = '0;
    pkt_send_go      = 1'b0;
    pkt_tail         = 1'b0;
    dsc_last_tail    = 1'b0;
    que_wt_ack       = 1'b0;
    err_clr          = 1'b0;
    repeat (4) @(posedge user_clk);
    #1;
    reset_n = 1'b1;
    next_cycle();

    check_reset_state();
    split_packets_all_modes();
    fill_and_overflow();
    retire_in_order();
    zero_length_dsc();
    gate_and_clear();

    $display("tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: rtl/cmpl_track.sv
`timescale 1ns/1ps

module cmpl_track (
  input  logic user_clk,
  input  logic reset_n,
  input  logic rxch_clr,
  input  logic dsc_last_tail,
  input  logic zero_len_done,
  input  logic que_wt_ack,
  input  logic pkt_send_go,
  input  logic pkt_tail,
  input  logic dscq_used,
  output logic que_wt_req,
  output logic dmar_busy,
  output logic req_udfl_err
);

  logic [2:0]  req_cnt;
  logic [11:0] inflight_cnt;
  logic        req_dec;

  assign que_wt_req   = (req_cnt != '0);
  assign req_dec      = que_wt_ack & que_wt_req;
  assign req_udfl_err = que_wt_ack & ~que_wt_req;

  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      req_cnt      <= '0;
      inflight_cnt <= '0;
      dmar_busy    <= 1'b0;
    end else begin
      if (rxch_clr) begin
        req_cnt <= '0;
      end else begin
        req_cnt <= req_cnt + 3'(dsc_last_tail) + 3'(zero_len_done) - 3'(req_dec);
      end
      inflight_cnt <= inflight_cnt + 12'(pkt_send_go) - 12'(pkt_tail);
      dmar_busy    <= dscq_used | que_wt_req | (inflight_cnt != '0);
    end
  end

  // every tail belongs to a packet taken earlier
  a_inflight_no_wrap: assert property (
    @(posedge user_clk) disable iff (!reset_n)
    (pkt_tail && !pkt_send_go) |-> (inflight_cnt != '0)
  );

endmodule

// File: rtl/dma_rx.sv
`timescale 1ns/1ps

module dma_rx import dma_rx_pkg::*; #(
  parameter int DSCQ_DEPTH = 4
) (
  input  logic      user_clk,
  input  logic      reset_n,
  input  max_mode_t pkt_max_len_mode,
  input  logic      rxch_rd_enb,
  input  logic      rxch_clr,
  input  logic      dscq_we,
  input  addr_t     dsc_src_addr,
  input  len_t      dsc_src_len,
  input  task_id_t  dsc_task_id,
  input  logic      pkt_send_go,
  input  logic      pkt_tail,
  input  logic      dsc_last_tail,
  input  logic      que_wt_ack,
  input  logic      err_clr,
  output logic      dscq_full,
  output logic      pkt_send_valid,
  output addr_t     pkt_send_addr,
  output pkt_num_t  pkt_num,
  output pkt_cyc_t  pkt_sta_cycle,
  output pkt_cyc_t  pkt_end_cycle,
  output pkt_num_t  pkt_send_idx,
  output logic      que_wt_req,
  output task_id_t  que_wt_task_id,
  output logic      dmar_busy,
  output err_vec_t  rx_err
);

  addr_t    head_addr;
  len_t     head_len;
  logic     head_valid;
  logic     dscq_used;
  logic     send_done;
  logic     zero_len_done;
  logic     plan_valid;
  addr_t    plan_addr;
  logic     plan_zero_len;
  logic     ovfl_err;
  logic     send_udfl_err;
  logic     retire_udfl_err;
  logic     req_udfl_err;
  err_vec_t err_set;

  // error sources gathered by bit index
  assign err_set[err_dscq_wr_ovfl] = ovfl_err;
  assign err_set[err_send_rd_udfl] = send_udfl_err;
  assign err_set[err_retire_udfl]  = retire_udfl_err;
  assign err_set[err_req_udfl]     = req_udfl_err;

  dscq #(
    .DSCQ_DEPTH(DSCQ_DEPTH)
  ) u_dscq (
    .user_clk        (user_clk),
    .reset_n         (reset_n),
    .rxch_clr        (rxch_clr),
    .dscq_we         (dscq_we),
    .dsc_src_addr    (dsc_src_addr),
    .dsc_src_len     (dsc_src_len),
    .dsc_task_id     (dsc_task_id),
    .send_done       (send_done),
    .que_wt_ack      (que_wt_ack),
    .dscq_full       (dscq_full),
    .head_addr       (head_addr),
    .head_len        (head_len),
    .head_valid      (head_valid),
    .que_wt_task_id  (que_wt_task_id),
    .dscq_used       (dscq_used),
    .ovfl_err        (ovfl_err),
    .send_udfl_err   (send_udfl_err),
    .retire_udfl_err (retire_udfl_err)
  );

  pkt_plan u_pkt_plan (
    .user_clk         (user_clk),
    .reset_n          (reset_n),
    .head_addr        (head_addr),
    .head_len         (head_len),
    .head_valid       (head_valid),
    .pkt_max_len_mode (pkt_max_len_mode),
    .plan_valid       (plan_valid),
    .plan_addr        (plan_addr),
    .plan_zero_len    (plan_zero_len),
    .pkt_num          (pkt_num),
    .pkt_sta_cycle    (pkt_sta_cycle),
    .pkt_end_cycle    (pkt_end_cycle)
  );

  pkt_issue u_pkt_issue (
    .user_clk         (user_clk),
    .reset_n          (reset_n),
    .rxch_rd_enb      (rxch_rd_enb),
    .rxch_clr         (rxch_clr),
    .plan_valid       (plan_valid),
    .plan_addr        (plan_addr),
    .plan_zero_len    (plan_zero_len),
    .pkt_num          (pkt_num),
    .pkt_max_len_mode (pkt_max_len_mode),
    .pkt_send_go      (pkt_send_go),
    .pkt_send_valid   (pkt_send_valid),
    .pkt_send_addr    (pkt_send_addr),
    .pkt_send_idx     (pkt_send_idx),
    .send_done        (send_done),
    .zero_len_done    (zero_len_done)
  );

  cmpl_track u_cmpl_track (
    .user_clk      (user_clk),
    .reset_n       (reset_n),
    .rxch_clr      (rxch_clr),
    .dsc_last_tail (dsc_last_tail),
    .zero_len_done (zero_len_done),
    .que_wt_ack    (que_wt_ack),
    .pkt_send_go   (pkt_send_go),
    .pkt_tail      (pkt_tail),
    .dscq_used     (dscq_used),
    .que_wt_req    (que_wt_req),
    .dmar_busy     (dmar_busy),
    .req_udfl_err  (req_udfl_err)
  );

  rx_err_reg u_rx_err_reg (
    .user_clk (user_clk),
    .reset_n  (reset_n),
    .err_set  (err_set),
    .err_clr  (err_clr),
    .rx_err   (rx_err)
  );

endmodule

// File: rtl/dma_rx_pkg.sv
package dma_rx_pkg;

  // byte address and byte length of a descriptor
  typedef logic [63:0] addr_t;
  typedef logic [31:0] len_t;

  // counts in 64-byte cycles
  typedef logic [25:0] cyc_t;
  typedef logic [25:0] pkt_num_t;
  typedef logic [4:0]  pkt_cyc_t;

  typedef logic [15:0] task_id_t;
  typedef logic [2:0]  max_mode_t;
  typedef logic [3:0]  err_vec_t;

  // bit positions in rx_err
  typedef enum int unsigned {
    err_dscq_wr_ovfl = 0,
    err_send_rd_udfl = 1,
    err_retire_udfl  = 2,
    err_req_udfl     = 3
  } err_idx_e;

  // log2 of the 64-byte cycle
  localparam int CYC_SHIFT = 6;

  // packet maximum is 2**mode cycles with mode limited to 4 (16 cycles)
  function automatic max_mode_t clamp_mode(max_mode_t mode);
    max_mode_t res;
    res = (mode > 3'd4) ? 3'd4 : mode;
    return res;
  endfunction

endpackage

// File: rtl/dscq.sv
`timescale 1ns/1ps

module dscq import dma_rx_pkg::*; #(
  parameter int DSCQ_DEPTH = 4
) (
  input  logic     user_clk,
  input  logic     reset_n,
  input  logic     rxch_clr,
  input  logic     dscq_we,
  input  addr_t    dsc_src_addr,
  input  len_t     dsc_src_len,
  input  task_id_t dsc_task_id,
  input  logic     send_done,
  input  logic     que_wt_ack,
  output logic     dscq_full,
  output addr_t    head_addr,
  output len_t     head_len,
  output logic     head_valid,
  output task_id_t que_wt_task_id,
  output logic     dscq_used,
  output logic     ovfl_err,
  output logic     send_udfl_err,
  output logic     retire_udfl_err
);

  localparam int PTR_W = (DSCQ_DEPTH > 1) ? $clog2(DSCQ_DEPTH) : 1;
  localparam int CNT_W = $clog2(DSCQ_DEPTH + 1);

  addr_t            addr_q [DSCQ_DEPTH];
  len_t             len_q  [DSCQ_DEPTH];
  task_id_t         task_q [DSCQ_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] send_ptr;
  logic [PTR_W-1:0] ret_ptr;
  logic [CNT_W-1:0] pend_cnt;
  logic [CNT_W-1:0] used_cnt;
  logic             wr_en;
  logic             send_re;
  logic             ret_re;

  // wraps at the queue depth even when it is not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    nxt = (ptr == PTR_W'(DSCQ_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    return nxt;
  endfunction

  assign dscq_full  = (used_cnt == CNT_W'(DSCQ_DEPTH));
  assign head_valid = (pend_cnt != '0);
  assign dscq_used  = (used_cnt != '0);

  // writes while full are dropped
  assign wr_en   = dscq_we & ~dscq_full & ~rxch_clr;
  assign send_re = send_done & head_valid;
  assign ret_re  = que_wt_ack & dscq_used;

  assign ovfl_err        = dscq_we & dscq_full;
  assign send_udfl_err   = send_done & ~head_valid;
  assign retire_udfl_err = que_wt_ack & ~dscq_used;

  assign head_addr      = addr_q[send_ptr];
  assign head_len       = len_q[send_ptr];
  assign que_wt_task_id = task_q[ret_ptr];

  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr   <= '0;
      send_ptr <= '0;
      ret_ptr  <= '0;
      pend_cnt <= '0;
      used_cnt <= '0;
    end else if (rxch_clr) begin
      wr_ptr   <= '0;
      send_ptr <= '0;
      ret_ptr  <= '0;
      pend_cnt <= '0;
      used_cnt <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (send_re) begin
        send_ptr <= ptr_inc(send_ptr);
      end
      if (ret_re) begin
        ret_ptr <= ptr_inc(ret_ptr);
      end
      pend_cnt <= pend_cnt + CNT_W'(wr_en) - CNT_W'(send_re);
      used_cnt <= used_cnt + CNT_W'(wr_en) - CNT_W'(ret_re);
    end
  end

  // entries stored cycle-aligned
  always_ff @(posedge user_clk) begin
    if (wr_en) begin
      addr_q[wr_ptr] <= {dsc_src_addr[63:CYC_SHIFT], {CYC_SHIFT{1'b0}}};
      len_q[wr_ptr]  <= {dsc_src_len[31:CYC_SHIFT], {CYC_SHIFT{1'b0}}};
      task_q[wr_ptr] <= dsc_task_id;
    end
  end

  // an entry is never sent after it has been retired
  a_pend_le_used: assert property (
    @(posedge user_clk) disable iff (!reset_n) pend_cnt <= used_cnt
  );

endmodule

// File: rtl/pkt_issue.sv
`timescale 1ns/1ps

module pkt_issue import dma_rx_pkg::*; (
  input  logic      user_clk,
  input  logic      reset_n,
  input  logic      rxch_rd_enb,
  input  logic      rxch_clr,
  input  logic      plan_valid,
  input  addr_t     plan_addr,
  input  logic      plan_zero_len,
  input  pkt_num_t  pkt_num,
  input  max_mode_t pkt_max_len_mode,
  input  logic      pkt_send_go,
  output logic      pkt_send_valid,
  output addr_t     pkt_send_addr,
  output pkt_num_t  pkt_send_idx,
  output logic      send_done,
  output logic      zero_len_done
);

  max_mode_t mode_c;
  addr_t     step;
  logic      take;
  logic      last;
  logic      hold_1tc;

  assign mode_c = clamp_mode(pkt_max_len_mode);
  // bytes per max-size packet
  assign step   = (addr_t'(1) << CYC_SHIFT) << mode_c;

  assign take = pkt_send_go & pkt_send_valid;
  assign last = ((pkt_send_idx + pkt_num_t'(1)) == pkt_num);

  // plan is stale for one cycle after the send pointer moves
  assign zero_len_done = plan_valid & plan_zero_len & rxch_rd_enb & ~rxch_clr & ~hold_1tc;
  assign send_done     = (take & last) | zero_len_done;

  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      pkt_send_valid <= 1'b0;
      hold_1tc       <= 1'b0;
      pkt_send_idx   <= '0;
    end else begin
      hold_1tc       <= send_done | rxch_clr;
      pkt_send_valid <= rxch_rd_enb & ~rxch_clr & plan_valid & ~plan_zero_len
                        & ~send_done & ~hold_1tc;
      if (rxch_clr) begin
        pkt_send_idx <= '0;
      end else if (take) begin
        pkt_send_idx <= last ? '0 : pkt_send_idx + pkt_num_t'(1);
      end
    end
  end

  // later packets start on max-size boundaries
  always_ff @(posedge user_clk) begin
    if (take && !last) begin
      pkt_send_addr <= (pkt_send_addr & ~(step - addr_t'(1))) + step;
    end else if (!take && pkt_send_idx == '0) begin
      pkt_send_addr <= plan_addr;
    end
  end

  a_go_needs_valid: assert property (
    @(posedge user_clk) disable iff (!reset_n) pkt_send_go |-> pkt_send_valid
  );

endmodule

// File: rtl/pkt_plan.sv
`timescale 1ns/1ps

module pkt_plan import dma_rx_pkg::*; (
  input  logic      user_clk,
  input  logic      reset_n,
  input  addr_t     head_addr,
  input  len_t      head_len,
  input  logic      head_valid,
  input  max_mode_t pkt_max_len_mode,
  output logic      plan_valid,
  output addr_t     plan_addr,
  output logic      plan_zero_len,
  output pkt_num_t  pkt_num,
  output pkt_cyc_t  pkt_sta_cycle,
  output pkt_cyc_t  pkt_end_cycle
);

  max_mode_t   mode_c;
  pkt_cyc_t    max_cyc;
  logic [3:0]  off_cyc;
  pkt_cyc_t    first_cyc;
  cyc_t        len_cyc;
  cyc_t        rem_cyc;
  cyc_t        rem_lo;
  logic [26:0] rem_up;
  pkt_num_t    num_c;
  pkt_cyc_t    sta_c;
  pkt_cyc_t    end_c;

  always_comb begin
    mode_c    = clamp_mode(pkt_max_len_mode);
    max_cyc   = pkt_cyc_t'(1) << mode_c;
    // cycle offset inside the first max-size window
    off_cyc   = head_addr[CYC_SHIFT +: 4] & (max_cyc[3:0] - 4'd1);
    first_cyc = max_cyc - {1'b0, off_cyc};
    len_cyc   = head_len[31:CYC_SHIFT];
    rem_cyc   = len_cyc - cyc_t'(first_cyc);
    rem_up    = {1'b0, rem_cyc} + 27'(max_cyc) - 27'd1;
    rem_lo    = rem_cyc & (cyc_t'(max_cyc) - cyc_t'(1));
    if (len_cyc <= cyc_t'(first_cyc)) begin
      // fits in one packet
      num_c = pkt_num_t'(1);
      sta_c = len_cyc[4:0];
      end_c = len_cyc[4:0];
    end else begin
      num_c = pkt_num_t'(rem_up >> mode_c) + pkt_num_t'(1);
      sta_c = first_cyc;
      end_c = (rem_lo == '0) ? max_cyc : rem_lo[4:0];
    end
  end

  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      plan_valid    <= 1'b0;
      plan_zero_len <= 1'b0;
    end else begin
      plan_valid    <= head_valid;
      plan_zero_len <= head_valid & (len_cyc == '0);
    end
  end

  always_ff @(posedge user_clk) begin
    plan_addr     <= head_addr;
    pkt_num       <= num_c;
    pkt_sta_cycle <= sta_c;
    pkt_end_cycle <= end_c;
  end

endmodule

// File: rtl/rx_err_reg.sv
`timescale 1ns/1ps

module rx_err_reg import dma_rx_pkg::*; (
  input  logic     user_clk,
  input  logic     reset_n,
  input  err_vec_t err_set,
  input  logic     err_clr,
  output err_vec_t rx_err
);

  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      rx_err <= '0;
    end else begin
      for (int i = 0; i < $bits(err_vec_t); i++) begin
        // write-one-clear beats a new set
        if (err_clr) begin
          rx_err[i] <= 1'b0;
        end else if (err_set[i]) begin
          rx_err[i] <= 1'b1;
        end
      end
    end
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the dma_rx testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f dma_rx.f --top-module tb_dma_rx \
  --Mdir "$OBJ" -o sim_dma_rx
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/sim_dma_rx" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1
